//--- design/l2_cache.sv
`timescale 1ns/1ps

module l2_cache #(
	parameter int s_index = 3	// 8 sets
) (
	input  logic                   clk,
	input  logic                   rst_i,
	input  l2_cache_pkg::cpu_req_t cpu_req_i,
	output l2_cache_pkg::cpu_rsp_t cpu_rsp_o,
	output l2_cache_pkg::mem_req_t mem_req_o,
	input  l2_cache_pkg::line_t    mem_rdata_i,
	input  logic                   mem_resp_i
);
	import l2_cache_pkg::*;

	ctrl_t   ctrl;
	status_t status;
	logic    cpu_resp;
	logic    mem_read;
	logic    mem_write;
	line_t   cpu_rdata;
	line_t   mem_wdata;
	addr_t   mem_addr;

	l2_cache_control u_control (
		.clk         (clk),
		.rst_i       (rst_i),
		.cpu_req_i   (cpu_req_i),
		.status_i    (status),
		.mem_resp_i  (mem_resp_i),
		.ctrl_o      (ctrl),
		.cpu_resp_o  (cpu_resp),
		.mem_read_o  (mem_read),
		.mem_write_o (mem_write)
	);

	l2_cache_datapath #(.s_index(s_index)) u_datapath (
		.clk         (clk),
		.rst_i       (rst_i),
		.cpu_req_i   (cpu_req_i),
		.mem_rdata_i (mem_rdata_i),
		.ctrl_i      (ctrl),
		.status_o    (status),
		.cpu_rdata_o (cpu_rdata),
		.mem_addr_o  (mem_addr),
		.mem_wdata_o (mem_wdata)
	);

	assign cpu_rsp_o = '{resp: cpu_resp, rdata: cpu_rdata};
	assign mem_req_o = '{address: mem_addr, read: mem_read, write: mem_write, wdata: mem_wdata};

endmodule

//--- design/l2_cache_control.sv
`timescale 1ns/1ps

module l2_cache_control (
	input  logic                   clk,
	input  logic                   rst_i,
	input  l2_cache_pkg::cpu_req_t cpu_req_i,
	input  l2_cache_pkg::status_t  status_i,
	input  logic                   mem_resp_i,
	output l2_cache_pkg::ctrl_t    ctrl_o,
	output logic                   cpu_resp_o,
	output logic                   mem_read_o,
	output logic                   mem_write_o
);
	import l2_cache_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_writeback,
		st_fill,
		st_respond
	} state_e;

	state_e state_q;
	state_e state_d;
	logic   req_valid;
	logic   victim;	// way chosen on a miss
	logic   victim_q;

	assign req_valid = cpu_req_i.read || cpu_req_i.write;

	// invalid way first, else the lru way
	always_comb begin
		if (!status_i.valid[0])
			victim = 1'b0;
		else if (!status_i.valid[1])
			victim = 1'b1;
		else
			victim = status_i.lru;
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q  <= st_idle;
			victim_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == st_lookup)
				victim_q <= victim;
		end
	end

	always_comb begin
		state_d          = state_q;
		ctrl_o           = '0;
		ctrl_o.dout_sel  = none;
		ctrl_o.maddr_sel = cpu_addr;
		cpu_resp_o       = 1'b0;
		mem_read_o       = 1'b0;
		mem_write_o      = 1'b0;

		unique case (state_q)
			st_idle: begin
				if (req_valid) begin
					ctrl_o.arr_read = 1'b1;	// latch set contents
					state_d         = st_lookup;
				end
			end

			st_lookup: begin
				if (status_i.hit) begin
					cpu_resp_o      = 1'b1;
					ctrl_o.dout_sel = status_i.hit_way ? way1 : way0;
					ctrl_o.lru_load = 1'b1;
					ctrl_o.lru_in   = ~status_i.hit_way;
					if (cpu_req_i.write) begin
						ctrl_o.wen_sel[status_i.hit_way]    = byte_enable;
						ctrl_o.din_sel[status_i.hit_way]    = cpu_data;
						ctrl_o.dirty_load[status_i.hit_way] = 1'b1;
						ctrl_o.dirty_in[status_i.hit_way]   = 1'b1;
					end
					state_d = st_idle;
				end else if (status_i.valid[victim] && status_i.dirty[victim]) begin
					state_d = st_writeback;
				end else begin
					state_d = st_fill;
				end
			end

			st_writeback: begin
				mem_write_o      = 1'b1;
				ctrl_o.dout_sel  = victim_q ? way1 : way0;
				ctrl_o.maddr_sel = victim_q ? tag1_addr : tag0_addr;
				if (mem_resp_i)
					state_d = st_fill;
			end

			st_fill: begin
				mem_read_o = 1'b1;
				if (mem_resp_i) begin
					ctrl_o.wen_sel[victim_q]    = all_ones;
					ctrl_o.din_sel[victim_q]    = cpu_req_i.write ? fill_merged : fill;
					ctrl_o.tag_load[victim_q]   = 1'b1;
					ctrl_o.valid_load[victim_q] = 1'b1;
					ctrl_o.valid_in[victim_q]   = 1'b1;
					ctrl_o.dirty_load[victim_q] = 1'b1;
					ctrl_o.dirty_in[victim_q]   = cpu_req_i.write;	// write miss leaves line dirty
					state_d                     = st_respond;
				end
			end

			st_respond: begin
				cpu_resp_o      = 1'b1;
				ctrl_o.dout_sel = victim_q ? way1 : way0;	// read port holds the fill
				ctrl_o.lru_load = 1'b1;
				ctrl_o.lru_in   = ~victim_q;
				state_d         = st_idle;
			end

			default: state_d = st_idle;
		endcase
	end

endmodule

//--- design/l2_cache_datapath.sv
`timescale 1ns/1ps

module l2_cache_datapath #(
	parameter int s_index = 3
) (
	input  logic                   clk,
	input  logic                   rst_i,
	input  l2_cache_pkg::cpu_req_t cpu_req_i,
	input  l2_cache_pkg::line_t    mem_rdata_i,
	input  l2_cache_pkg::ctrl_t    ctrl_i,
	output l2_cache_pkg::status_t  status_o,
	output l2_cache_pkg::line_t    cpu_rdata_o,
	output l2_cache_pkg::addr_t    mem_addr_o,
	output l2_cache_pkg::line_t    mem_wdata_o
);
	import l2_cache_pkg::*;

	localparam int s_tag = addr_w - s_offset - s_index;

	typedef logic [s_tag-1:0] tag_t;

	tag_t               tag;
	logic [s_index-1:0] index;
	tag_t [1:0]         tag_q;
	line_t [1:0]        line_q;
	logic [1:0]         valid_q;
	logic [1:0]         dirty_q;
	logic               lru_q;
	logic [1:0]         way_hit;
	line_t              merged;	// cpu bytes over the fill line
	line_t              dout;

	// offset bits are ignored, the cache moves whole lines
	assign tag   = cpu_req_i.address[addr_w-1 -: s_tag];
	assign index = cpu_req_i.address[s_offset +: s_index];

	for (genvar w = 0; w < 2; w++) begin : g_way
		mask_t wen;
		line_t din;

		always_comb begin
			unique case (ctrl_i.wen_sel[w])
				zero:        wen = '0;
				all_ones:    wen = '1;
				byte_enable: wen = cpu_req_i.byte_enable;
				default:     wen = '0;
			endcase
		end

		always_comb begin
			unique case (ctrl_i.din_sel[w])
				fill_merged: din = merged;	// write miss
				cpu_data:    din = cpu_req_i.wdata;	// write hit, wen masks it
				fill:        din = mem_rdata_i;
				default:     din = mem_rdata_i;
			endcase
		end

		line_array #(.s_index(s_index)) u_data (
			.clk     (clk),
			.rst_i   (rst_i),
			.read_i  (ctrl_i.arr_read),
			.index_i (index),
			.wen_i   (wen),
			.data_i  (din),
			.data_o  (line_q[w])
		);

		meta_array #(.s_index(s_index), .payload_t(tag_t)) u_tag (
			.clk     (clk),
			.rst_i   (rst_i),
			.read_i  (ctrl_i.arr_read),
			.load_i  (ctrl_i.tag_load[w]),
			.index_i (index),
			.data_i  (tag),
			.data_o  (tag_q[w])
		);

		meta_array #(.s_index(s_index), .payload_t(logic)) u_valid (
			.clk     (clk),
			.rst_i   (rst_i),
			.read_i  (ctrl_i.arr_read),
			.load_i  (ctrl_i.valid_load[w]),
			.index_i (index),
			.data_i  (ctrl_i.valid_in[w]),
			.data_o  (valid_q[w])
		);

		meta_array #(.s_index(s_index), .payload_t(logic)) u_dirty (
			.clk     (clk),
			.rst_i   (rst_i),
			.read_i  (ctrl_i.arr_read),
			.load_i  (ctrl_i.dirty_load[w]),
			.index_i (index),
			.data_i  (ctrl_i.dirty_in[w]),
			.data_o  (dirty_q[w])
		);

		assign way_hit[w] = valid_q[w] && (tag_q[w] == tag);
	end

	// one lru bit per set shared by both ways
	meta_array #(.s_index(s_index), .payload_t(logic)) u_lru (
		.clk     (clk),
		.rst_i   (rst_i),
		.read_i  (ctrl_i.arr_read),
		.load_i  (ctrl_i.lru_load),
		.index_i (index),
		.data_i  (ctrl_i.lru_in),
		.data_o  (lru_q)
	);

	always_comb begin
		for (int i = 0; i < mask_w; i++) begin
			merged[8*i +: 8] = cpu_req_i.byte_enable[i] ? cpu_req_i.wdata[8*i +: 8]
				: mem_rdata_i[8*i +: 8];
		end
	end

	always_comb begin
		unique case (ctrl_i.dout_sel)
			way0:    dout = line_q[0];
			way1:    dout = line_q[1];
			none:    dout = '0;
			default: dout = '0;
		endcase
	end

	// victim address rebuilt from the stored tag
	always_comb begin
		unique case (ctrl_i.maddr_sel)
			cpu_addr:  mem_addr_o = {cpu_req_i.address[addr_w-1:s_offset], {s_offset{1'b0}}};
			tag0_addr: mem_addr_o = {tag_q[0], index, {s_offset{1'b0}}};
			tag1_addr: mem_addr_o = {tag_q[1], index, {s_offset{1'b0}}};
			default:   mem_addr_o = {cpu_req_i.address[addr_w-1:s_offset], {s_offset{1'b0}}};
		endcase
	end

	assign cpu_rdata_o = dout;
	assign mem_wdata_o = dout;	// write-back data is the selected way

	assign status_o.hit     = |way_hit;
	assign status_o.hit_way = way_hit[1];
	assign status_o.valid   = valid_q;
	assign status_o.dirty   = dirty_q;
	assign status_o.lru     = lru_q;

endmodule

//--- design/l2_cache_pkg.sv
package l2_cache_pkg;

	localparam int addr_w   = 32;	// byte address
	localparam int s_offset = 5;	// byte within line
	localparam int line_w   = 256;
	localparam int mask_w   = 32;	// one enable per byte

	typedef logic [addr_w-1:0] addr_t;
	typedef logic [line_w-1:0] line_t;
	typedef logic [mask_w-1:0] mask_t;

	// upstream request, held until resp
	typedef struct packed {
		addr_t address;
		logic  read;
		logic  write;
		line_t wdata;
		mask_t byte_enable;
	} cpu_req_t;

	typedef struct packed {
		logic  resp;
		line_t rdata;
	} cpu_rsp_t;

	typedef struct packed {
		addr_t address;
		logic  read;
		logic  write;
		line_t wdata;
	} mem_req_t;

	typedef enum logic [1:0] {zero, all_ones, byte_enable} wen_sel_e;
	typedef enum logic [1:0] {way0, way1, none} dout_sel_e;
	typedef enum logic [1:0] {fill_merged, cpu_data, fill} din_sel_e;
	typedef enum logic [1:0] {cpu_addr, tag0_addr, tag1_addr} maddr_sel_e;

	// controller to datapath, one bit per way where indexed
	typedef struct packed {
		logic            arr_read;
		logic [1:0]      tag_load;
		logic [1:0]      valid_load;
		logic [1:0]      valid_in;
		logic [1:0]      dirty_load;
		logic [1:0]      dirty_in;
		logic            lru_load;
		logic            lru_in;
		wen_sel_e [1:0]  wen_sel;
		din_sel_e [1:0]  din_sel;
		dout_sel_e       dout_sel;
		maddr_sel_e      maddr_sel;
	} ctrl_t;

	typedef struct packed {
		logic       hit;
		logic       hit_way;
		logic [1:0] valid;
		logic [1:0] dirty;
		logic       lru;	// names the way to replace next
	} status_t;

endpackage

//--- design/line_array.sv
`timescale 1ns/1ps

module line_array #(
	parameter int s_index = 3
) (
	input  logic                [s_index-1:0] index_i,
	input  logic                              clk,
	input  logic                              rst_i,
	input  logic                              read_i,
	input  l2_cache_pkg::mask_t               wen_i,
	input  l2_cache_pkg::line_t               data_i,
	output l2_cache_pkg::line_t               data_o
);
	import l2_cache_pkg::*;

	localparam int num_sets = 2**s_index;

	line_t lines [num_sets];
	line_t rd_q;	// registered read port

	// storage, byte lanes written independently
	always_ff @(posedge clk) begin
		for (int i = 0; i < mask_w; i++) begin
			if (wen_i[i])
				lines[index_i][8*i +: 8] <= data_i[8*i +: 8];
		end
	end

	// written bytes show up on the read port in the same edge
	always_ff @(posedge clk) begin
		if (rst_i) begin
			rd_q <= '0;
		end else begin
			for (int i = 0; i < mask_w; i++) begin
				if (wen_i[i])
					rd_q[8*i +: 8] <= data_i[8*i +: 8];
				else if (read_i)
					rd_q[8*i +: 8] <= lines[index_i][8*i +: 8];
			end
		end
	end

	assign data_o = rd_q;

endmodule

//--- design/meta_array.sv
`timescale 1ns/1ps

module meta_array #(
	parameter int  s_index   = 3,
	parameter type payload_t = logic
) (
	input  logic               clk,
	input  logic               rst_i,
	input  logic               read_i,
	input  logic               load_i,
	input  logic [s_index-1:0] index_i,
	input  payload_t           data_i,
	output payload_t           data_o
);
	localparam int num_sets = 2**s_index;

	payload_t entries [num_sets];
	payload_t rd_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < num_sets; i++)
				entries[i] <= '0;	// every set starts invalid and clean
			rd_q <= '0;
		end else begin
			if (load_i)
				entries[index_i] <= data_i;
			if (load_i)
				rd_q <= data_i;	// bypass new value to read port
			else if (read_i)
				rd_q <= entries[index_i];
		end
	end

	assign data_o = rd_q;

endmodule

//--- project.f
design/l2_cache_pkg.sv
design/line_array.sv
design/meta_array.sv
design/l2_cache_datapath.sv
design/l2_cache_control.sv
design/l2_cache.sv
tests/l2_cache_properties.sv
tests/l2_cache_tb.sv

//--- tests/l2_cache_properties.sv
`timescale 1ns/1ps

module l2_cache_properties (
	input logic                   clk,
	input logic                   rst_i,
	input l2_cache_pkg::cpu_req_t cpu_req_i,
	input l2_cache_pkg::cpu_rsp_t cpu_rsp_i,
	input l2_cache_pkg::mem_req_t mem_req_i,
	input logic                   mem_resp_i
);
	int fail_count = 0;	// failed assertions so far

	mem_rw_exclusive: assert property (@(posedge clk) disable iff (rst_i)
		!(mem_req_i.read && mem_req_i.write))
		else begin
			fail_count++;
			$error("mem read and write high together");
		end

	// resp only answers a request that is still held
	resp_needs_req: assert property (@(posedge clk) disable iff (rst_i)
		cpu_rsp_i.resp |-> (cpu_req_i.read || cpu_req_i.write))
		else begin
			fail_count++;
			$error("cpu resp without a cpu request");
		end

	mem_req_stable: assert property (@(posedge clk) disable iff (rst_i)
		(mem_req_i.read || mem_req_i.write) && !mem_resp_i |=> $stable(mem_req_i))
		else begin
			fail_count++;
			$error("mem request changed before mem resp");
		end

	// first reset edge skipped, state is unknown before it
	quiet_in_reset: assert property (@(posedge clk)
		rst_i ##1 rst_i |-> !cpu_rsp_i.resp && !mem_req_i.read && !mem_req_i.write)
		else begin
			fail_count++;
			$error("resp or mem request high during reset");
		end

endmodule

bind l2_cache l2_cache_properties u_props (
	.clk        (clk),
	.rst_i      (rst_i),
	.cpu_req_i  (cpu_req_i),
	.cpu_rsp_i  (cpu_rsp_o),
	.mem_req_i  (mem_req_o),
	.mem_resp_i (mem_resp_i)
);

//--- tests/l2_cache_tb.sv
`timescale 1ns/1ps

module l2_cache_tb;
	import l2_cache_pkg::*;

	localparam int s_index       = 3;
	localparam int num_ops       = 223;	// cpu accesses over all tests
	localparam int cycles_per_op = 40;

	logic     clk = 1'b0;
	logic     rst_i;
	cpu_req_t cpu_req;
	cpu_rsp_t cpu_rsp;
	mem_req_t mem_req;
	line_t    mem_rdata;
	logic     mem_resp;

	line_t       mem_store [addr_t];	// lines written back so far
	line_t       shadow [addr_t];	// expected cpu view of each line
	int unsigned delays [1024];	// memory latencies, drawn up front
	int unsigned mem_delay;
	int          delay_idx = 0;
	int          rd_count = 0;
	int          wr_count = 0;
	addr_t       last_rd_addr;
	addr_t       last_wr_addr;
	line_t       last_wr_data;

	l2_cache #(.s_index(s_index)) dut_i (
		.clk         (clk),
		.rst_i       (rst_i),
		.cpu_req_i   (cpu_req),
		.cpu_rsp_o   (cpu_rsp),
		.mem_req_o   (mem_req),
		.mem_rdata_i (mem_rdata),
		.mem_resp_i  (mem_resp)
	);

	always #5 clk = ~clk;

	// power-on memory contents
	function automatic line_t init_line(input addr_t addr);
		line_t l;
		for (int w = 0; w < 8; w++)
			l[32*w +: 32] = (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ (w * 32'h0101_0101);
		return l;
	endfunction

	function automatic line_t mem_line(input addr_t addr);
		if (mem_store.exists(addr))
			return mem_store[addr];
		return init_line(addr);
	endfunction

	function automatic line_t expected_line(input addr_t addr);
		if (shadow.exists(addr))
			return shadow[addr];
		return init_line(addr);
	endfunction

	function automatic line_t merge_bytes(input line_t old, input line_t data, input mask_t be);
		line_t l;
		for (int i = 0; i < mask_w; i++)
			l[8*i +: 8] = be[i] ? data[8*i +: 8] : old[8*i +: 8];
		return l;
	endfunction

	function automatic line_t random_line();
		line_t l;
		for (int w = 0; w < 8; w++)
			l[32*w +: 32] = $urandom;
		return l;
	endfunction

	// 8 tags in each of sets 5, 6 and 7
	function automatic addr_t traffic_addr(input int i);
		return 32'h0001_0000 + addr_t'(i / 3) * 256 + addr_t'(5 + i % 3) * 32;
	endfunction

	task automatic abort_run(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic check_line(input string what, input line_t got, input line_t exp);
		if (got !== exp)
			abort_run($sformatf("%s: got %h, expected %h", what, got, exp));
	endtask

	task automatic check_addr(input string what, input addr_t got, input addr_t exp);
		if (got !== exp)
			abort_run($sformatf("%s: got %h, expected %h", what, got, exp));
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("%s: got %0d, expected %0d", what, got, exp));
	endtask

	// memory side, one transfer at a time
	always begin
		@(negedge clk);
		if (!rst_i && (mem_req.read || mem_req.write)) begin
			mem_delay = delays[delay_idx % 1024];
			delay_idx++;
			repeat (mem_delay - 1) @(negedge clk);
			if (mem_req.write) begin
				mem_store[mem_req.address] = mem_req.wdata;
				last_wr_addr = mem_req.address;
				last_wr_data = mem_req.wdata;
				wr_count++;
			end else begin
				mem_rdata    = mem_line(mem_req.address);
				last_rd_addr = mem_req.address;
				rd_count++;
			end
			mem_resp = 1'b1;
			@(negedge clk);
			mem_resp = 1'b0;
		end
	end

	task automatic access(input addr_t addr, input logic wr, input line_t wdata,
			input mask_t be, output line_t rdata);
		@(negedge clk);
		cpu_req.address     = addr;
		cpu_req.read        = !wr;
		cpu_req.write       = wr;
		cpu_req.wdata       = wdata;
		cpu_req.byte_enable = be;
		do
			@(negedge clk);
		while (!cpu_rsp.resp);
		rdata = cpu_rsp.rdata;
		@(negedge clk);	// held through the resp edge
		cpu_req = '0;
	endtask

	task automatic read_and_check(input addr_t addr);
		line_t got;
		access(addr, 1'b0, '0, '0, got);
		check_line($sformatf("read data at %h", addr), got, expected_line(addr));
	endtask

	task automatic write_bytes(input addr_t addr, input line_t data, input mask_t be);
		line_t unused;
		access(addr, 1'b1, data, be, unused);
		shadow[addr] = merge_bytes(expected_line(addr), data, be);
	endtask

	task automatic read_miss_then_hit();
		addr_t a = 32'h0000_1020;
		line_t first;
		line_t again;
		int    rd0 = rd_count;
		int    wr0 = wr_count;
		access(a, 1'b0, '0, '0, first);
		check_count("mem reads on first read", rd_count - rd0, 1);
		check_count("mem writes on first read", wr_count - wr0, 0);
		check_addr("fill address", last_rd_addr, a);
		check_line("first read vs backing store", first, mem_line(a));
		access(a, 1'b0, '0, '0, again);
		check_count("mem reads on repeat read", rd_count - rd0, 1);
		check_count("mem writes on repeat read", wr_count - wr0, 0);
		check_line("repeat read", again, mem_line(a));
	endtask

	task automatic write_hit_partial();
		addr_t a = 32'h0000_1020;	// resident since the first test
		int    rd0 = rd_count;
		int    wr0 = wr_count;
		write_bytes(a, random_line(), 32'h0000_ff0f);
		read_and_check(a);
		check_count("mem reads on write hit", rd_count - rd0, 0);
		check_count("mem writes on write hit", wr_count - wr0, 0);
	endtask

	task automatic write_miss_allocate();
		addr_t b = 32'h0000_2040;
		int    rd0 = rd_count;
		int    wr0 = wr_count;
		write_bytes(b, random_line(), 32'hf00f_00f0);
		check_count("mem reads on write miss", rd_count - rd0, 1);
		check_count("mem writes on write miss", wr_count - wr0, 0);
		check_addr("allocate address", last_rd_addr, b);
		read_and_check(b);
		check_count("mem reads on read-back", rd_count - rd0, 1);
	endtask

	task automatic dirty_eviction();
		addr_t x = 32'h0000_3060;
		addr_t y = 32'h0000_3160;
		addr_t z = 32'h0000_3260;
		addr_t w = 32'h0000_3360;
		int    rd0;
		int    wr0;
		write_bytes(x, random_line(), 32'h00ff_00ff);
		write_bytes(y, random_line(), 32'hff00_ff00);
		rd0 = rd_count;
		wr0 = wr_count;
		read_and_check(z);	// x is least recently used
		check_count("write-backs for dirty victim", wr_count - wr0, 1);
		check_addr("write-back address", last_wr_addr, x);
		check_line("write-back data", last_wr_data, expected_line(x));
		check_count("fills for dirty victim", rd_count - rd0, 1);
		read_and_check(y);	// z, clean, becomes lru
		rd0 = rd_count;
		wr0 = wr_count;
		read_and_check(w);
		check_count("write-backs for clean victim", wr_count - wr0, 0);
		check_count("fills for clean victim", rd_count - rd0, 1);
	endtask

	task automatic lru_order();
		addr_t a = 32'h0000_4080;
		addr_t b = 32'h0000_4180;
		addr_t c = 32'h0000_4280;
		int    rd0;
		read_and_check(a);
		read_and_check(b);
		read_and_check(a);
		read_and_check(c);	// b is older than a
		rd0 = rd_count;
		read_and_check(a);
		check_count("mem reads for a after c", rd_count - rd0, 0);
		read_and_check(b);
		check_count("mem reads for b after c", rd_count - rd0, 1);
		check_addr("refill address of b", last_rd_addr, b);
	endtask

	task automatic random_traffic();
		addr_t a;
		for (int n = 0; n < 200; n++) begin
			a = traffic_addr($urandom % 24);
			if ($urandom % 2)
				write_bytes(a, random_line(), mask_t'($urandom));
			else
				read_and_check(a);
		end
		// two fresh lines per set push every dirty line out
		for (int s = 5; s < 8; s++) begin
			read_and_check(32'h0002_0000 + s * 32);
			read_and_check(32'h0002_0100 + s * 32);
		end
		for (int i = 0; i < 24; i++) begin
			a = traffic_addr(i);
			check_line($sformatf("memory line at %h", a), mem_line(a), expected_line(a));
		end
	endtask

	initial begin
		void'($urandom(32'h26ffc1ca));
		rst_i     = 1'b1;
		cpu_req   = '0;
		mem_rdata = '0;
		mem_resp  = 1'b0;
		foreach (delays[i])
			delays[i] = 1 + ($urandom % 4);	// 1 to 4 cycles
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;

		read_miss_then_hit();
		write_hit_partial();
		write_miss_allocate();
		dirty_eviction();
		lru_order();
		random_traffic();

		if (dut_i.u_props.fail_count != 0) begin
			$display("%0d handshake assertion failures", dut_i.u_props.fail_count);
			$display("Simulation finished: FAIL");
			$fatal(1, "assertion failures");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

	// generous bound per access, misses take about a dozen cycles
	initial begin
		repeat (num_ops * cycles_per_op) @(posedge clk);
		$display("timeout: tests still running after %0d cycles", num_ops * cycles_per_op);
		$display("Simulation finished: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule
